//--- tb.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_fetch.sv
logic/stage_decode.sv
logic/reorder_buffer.sv
logic/exec_unit.sv
logic/ooo.sv
logic/cpu.sv
tb/cpu_tb.sv

//--- Makefile
# Verilator simulation of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import isa_pkg::*;
;

    localparam int clk_period  = 40;
    localparam int num_tests   = 6;
    localparam int prog_words  = 64;
    // tests x instructions x cycles per instruction x period
    localparam int watchdog_ns = num_tests * prog_words * 40 * clk_period;

    logic       clock;
    logic       rst_n;
    logic       imem_req_ready;
    logic       imem_rsp_valid;
    inst_t      imem_rsp_data;
    logic       imem_req_valid;
    addr_t      imem_req_addr;
    logic       commit_valid;
    logic       commit_wr_en;
    reg_idx_t   commit_wr_idx;
    data_t      commit_wr_data;
    addr_t      commit_npc;
    exception_e commit_status;

    // instruction memory image, full 8-bit address space
    inst_t prog [256];

    // reference model state
    data_t      model_regs [arch_regs];
    addr_t      model_pc;
    logic       model_stopped;
    exception_e stop_status;
    int         commit_total;

    logic [31:0] lfsr        = 32'h9c70_b34e;
    logic        slow_memory = 1'b0;
    logic        ready_half  = 1'b0;
    int          error_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;

    cpu cpu_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .commit_status  (commit_status)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////////////////

    // galois form, one step per bit
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // program generation
    //////////////////////////////////////////////////////////////

    task automatic gen_program(input int id);
        inst_t w;
        int    reg_bits;
        int    pick;
        int    off;
        // filler past the program, never committed
        for (int a = 0; a < 256; a++) begin
            w        = '0;
            w.opcode = op_halt;
            w.rd     = reg_idx_t'(a);
            w.imm    = {a[7:0], ~a[7:0]};
            prog[a]  = w;
        end
        // few registers means many dependencies
        reg_bits = (id == 2) ? 1 : (id == 3) ? 2 : 3;
        for (int i = 0; i < prog_words - 1; i++) begin
            if (id <= 2) begin
                pick = rand_bits(3) % 6;
            end else if (rand_bits(2) == 0) begin
                pick = op_beq;
            end else begin
                pick = rand_bits(3) % 6;
            end
            w.opcode = 4'(pick);
            w.rd     = reg_idx_t'(rand_bits(reg_bits));
            w.rs1    = reg_idx_t'(rand_bits(reg_bits));
            w.rs2    = reg_idx_t'(rand_bits(reg_bits));
            w.spare  = 3'(rand_bits(3));
            // small constants make beq operands equal more often
            w.imm    = (id == 3) ? rand_bits(2) : rand_bits(16);
            if (id == 5 && rand_bits(4) == 0) begin
                w.opcode = 4'd8 + 4'(rand_bits(3));
            end
            if (w.opcode == op_beq) begin
                // forward only, target stays inside the program
                off = rand_bits(2);
                if (off > prog_words - 2 - i) begin
                    off = prog_words - 2 - i;
                end
                w.imm = data_t'(off);
            end
            prog[i] = w;
        end
        w        = '0;
        w.opcode = op_halt;
        prog[prog_words-1] = w;
    endtask

    //////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////

    // sample before the edge, drive just after it
    initial begin
        logic  rst_s;
        logic  fire;
        addr_t addr_s;
        logic  slot_full;
        addr_t slot_addr;
        int    wait_cnt;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        slot_full      = 1'b0;
        slot_addr      = '0;
        wait_cnt       = 0;
        forever begin
            @(negedge clock);
            rst_s  = rst_n;
            fire   = imem_req_valid && imem_req_ready;
            addr_s = imem_req_addr;
            @(posedge clock);
            #2;
            imem_rsp_valid = 1'b0;
            if (!rst_s) begin
                slot_full = 1'b0;
            end else if (fire) begin
                slot_full = 1'b1;
                slot_addr = addr_s;
                wait_cnt  = slow_memory ? rand_bits(3) % 6 : 0;
            end
            if (slot_full) begin
                if (wait_cnt == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp_data  = prog[slot_addr];
                    slot_full      = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
            if (!slow_memory) begin
                imem_req_ready = 1'b1;
            end else if (ready_half) begin
                imem_req_ready = next_bit();
            end else begin
                imem_req_ready = (rand_bits(2) != 0);
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // isa model and commit checks
    //////////////////////////////////////////////////////////////

    task automatic check_commit();
        inst_t      w;
        data_t      a;
        data_t      b;
        data_t      value;
        logic       wr_en;
        addr_t      npc;
        exception_e status;
        w      = prog[model_pc];
        a      = model_regs[w.rs1];
        b      = model_regs[w.rs2];
        value  = '0;
        wr_en  = 1'b1;
        npc    = model_pc + 8'd1;
        status = no_error;
        if (model_stopped) begin
            $display("a commit appeared at %0t after the core had stopped", $time);
            error_count++;
        end
        case (w.opcode)
            op_add:  value = a + b;
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_xor:  value = a ^ b;
            op_addi: value = a + w.imm;
            op_li:   value = w.imm;
            op_beq: begin
                wr_en = 1'b0;
                // taken goes to pc + 1 + offset, 8-bit wrap
                if (a == b) begin
                    npc = model_pc + 8'd1 + w.imm[7:0];
                end
            end
            op_halt: begin
                wr_en  = 1'b0;
                status = halted;
            end
            default: begin
                wr_en  = 1'b0;
                status = illegal_inst;
            end
        endcase
        check_value($sformatf("status at pc %0d", model_pc), commit_status, status);
        check_value($sformatf("wr_en at pc %0d", model_pc), commit_wr_en, wr_en);
        check_value($sformatf("npc at pc %0d", model_pc), commit_npc, npc);
        if (wr_en) begin
            check_value($sformatf("wr_idx at pc %0d", model_pc), commit_wr_idx, w.rd);
            check_value($sformatf("wr_data at pc %0d", model_pc), commit_wr_data, value);
            model_regs[w.rd] = value;
        end
        if (status != no_error) begin
            model_stopped = 1'b1;
            stop_status   = status;
        end
        model_pc = npc;
        commit_total++;
    endtask

    initial begin
        forever begin
            @(negedge clock);
            if (!rst_n) begin
                for (int r = 0; r < arch_regs; r++) begin
                    model_regs[r] = '0;
                end
                model_pc      = '0;
                model_stopped = 1'b0;
                stop_status   = no_error;
                commit_total  = 0;
            end else if (commit_valid) begin
                check_commit();
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // test sequencing
    //////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clock);
        #2;
        rst_n = 1'b0;
        for (int c = 0; c < 8; c++) begin
            @(negedge clock);
            // first negedge comes before any reset edge
            if (c > 0) begin
                check_value("imem_req_valid in reset", imem_req_valid, 1'b0);
                check_value("commit_valid in reset", commit_valid, 1'b0);
            end
            @(posedge clock);
        end
        #2;
        rst_n = 1'b1;
        @(negedge clock);
        @(negedge clock);
        check_value("first request valid", imem_req_valid, 1'b1);
        check_value("first request address", imem_req_addr, 8'd0);
    endtask

    // core must stay silent once stopped
    task automatic check_quiet();
        int n;
        n = 0;
        // a request raised before the stop may still be waiting for ready
        while (imem_req_valid && n < 64) begin
            @(negedge clock);
            n++;
        end
        if (imem_req_valid) begin
            $display("the fetch request was still raised long after the core stopped");
            error_count++;
        end
        repeat (32) begin
            @(negedge clock);
            check_value("imem_req_valid after stop", imem_req_valid, 1'b0);
        end
    endtask

    task automatic run_test(input int id, input string name);
        int errors_before;
        errors_before = error_count;
        slow_memory   = (id >= 3);
        ready_half    = (id == 4);
        gen_program(id);
        apply_reset();
        if (id == 6) begin
            // reset again while the program is running
            repeat (30) @(posedge clock);
            apply_reset();
        end
        while (!model_stopped) begin
            @(negedge clock);
        end
        check_quiet();
        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s: %s, %0d commits, stop status %s", id, name,
                 (error_count == errors_before) ? "ok" : "failed",
                 commit_total, stop_status.name());
    endtask

    initial begin
        rst_n = 1'b0;
        run_test(1, "alu only");
        run_test(2, "dependent chains");
        run_test(3, "branches");
        run_test(4, "memory back-pressure");
        run_test(5, "halt and illegal");
        run_test(6, "reset mid-run");
        $display("tests passed %0d, failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, the core stopped committing", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  imem_req_ready,
    input  wire logic  imem_rsp_valid,
    input  wire inst_t imem_rsp_data,
    output logic       imem_req_valid,
    output addr_t      imem_req_addr,
    output logic       commit_valid,
    output logic       commit_wr_en,
    output reg_idx_t   commit_wr_idx,
    output data_t      commit_wr_data,
    output addr_t      commit_npc,
    output exception_e commit_status
);

    fetch_packet_t  fetch_packet;
    fetch_packet_t  if_id_reg;
    decode_packet_t decode_packet;
    decode_packet_t id_ooo_reg;

    // back end feedback
    logic           stall;      // rob full or source hazard
    logic           halt;
    redirect_t      redirect;   // valid doubles as squash
    commit_packet_t commit_packet;

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    stage_fetch fetch_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .stall          (stall),
        .halt           (halt),
        .redirect       (redirect),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .fetch_packet   (fetch_packet)
    );

    // squash wins over stall
    always_ff @(posedge clock) begin
        if (!rst_n || redirect.valid) begin
            if_id_reg <= '0;
        end else if (!stall) begin
            if_id_reg <= fetch_packet;
        end
    end

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    stage_decode decode_i (
        .fetch_packet  (if_id_reg),
        .decode_packet (decode_packet)
    );

    always_ff @(posedge clock) begin
        if (!rst_n || redirect.valid) begin
            id_ooo_reg <= '0;
        end else if (!stall) begin
            id_ooo_reg <= decode_packet;
        end
    end

    ////////////////////////////////////////////////////////////
    // back end
    ////////////////////////////////////////////////////////////

    ooo ooo_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .decode_packet (id_ooo_reg),
        .stall         (stall),
        .halt          (halt),
        .redirect      (redirect),
        .commit_packet (commit_packet)
    );

    // commit port
    assign commit_valid   = commit_packet.valid;
    assign commit_wr_en   = commit_packet.wr_en;
    assign commit_wr_idx  = commit_packet.wr_idx;
    assign commit_wr_data = commit_packet.wr_data;
    assign commit_npc     = commit_packet.npc;
    assign commit_status  = commit_packet.status;

endmodule

`default_nettype wire

//--- logic/ooo.sv
`timescale 1ns/1ps
`default_nettype none

module ooo
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic           clock,
    input  wire logic           rst_n,
    input  wire decode_packet_t decode_packet,
    output logic                stall,
    output logic                halt,
    output redirect_t           redirect,
    output commit_packet_t      commit_packet
);

    // in-flight writers per architectural register
    logic [$clog2(rob_size+1)-1:0] sb_count [arch_regs];
    logic [arch_regs-1:0]          sb_inc;
    logic [arch_regs-1:0]          sb_dec;

    logic         rob_full;
    logic         squash;
    logic         hazard;
    logic         issue_valid;
    rob_tag_t     issue_tag;
    exec_result_t exec_result;

    ////////////////////////////////////////////////////////////
    // issue control
    ////////////////////////////////////////////////////////////

    // any source with a pending writer waits
    assign hazard = (sb_count[decode_packet.rs1] != '0)
                 || (sb_count[decode_packet.rs2] != '0);

    assign stall       = decode_packet.valid && (rob_full || hazard);
    assign issue_valid = decode_packet.valid && !stall;

    // fetch latches this pulse
    assign halt = commit_packet.valid && (commit_packet.status != no_error);

    always_comb begin
        for (int r = 0; r < arch_regs; r++) begin
            sb_inc[r] = issue_valid && decode_packet.writes_rd
                     && (decode_packet.rd == reg_idx_t'(r));
            sb_dec[r] = commit_packet.valid && commit_packet.wr_en
                     && (commit_packet.wr_idx == reg_idx_t'(r));
        end
    end

    // squash empties the rob, so no writer survives
    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            for (int r = 0; r < arch_regs; r++) begin
                sb_count[r] <= '0;
            end
        end else begin
            for (int r = 0; r < arch_regs; r++) begin
                sb_count[r] <= sb_count[r] + sb_inc[r] - sb_dec[r];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // rob and execute
    ////////////////////////////////////////////////////////////

    reorder_buffer rob_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .alloc_valid   (issue_valid),
        .alloc_packet  (decode_packet),
        .exec_result   (exec_result),
        .alloc_tag     (issue_tag),
        .full          (rob_full),
        .commit_packet (commit_packet),
        .redirect      (redirect),
        .squash        (squash)
    );

    exec_unit exec_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_packet  (decode_packet),
        .issue_tag     (issue_tag),
        .commit_packet (commit_packet),
        .squash        (squash),
        .exec_result   (exec_result)
    );

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic           clock,
    input  wire logic           rst_n,
    input  wire logic           issue_valid,
    input  wire decode_packet_t issue_packet,
    input  wire rob_tag_t       issue_tag,
    input  wire commit_packet_t commit_packet,
    input  wire logic           squash,
    output exec_result_t        exec_result
);

    // architectural state, committed values only
    data_t regs [arch_regs];

    data_t src_a;
    data_t src_b;
    data_t alu_value;
    logic  taken;
    addr_t target;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int r = 0; r < arch_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (commit_packet.valid && commit_packet.wr_en) begin
            regs[commit_packet.wr_idx] <= commit_packet.wr_data;
        end
    end

    // scoreboard guarantees no pending writer, so the file is current
    assign src_a = regs[issue_packet.rs1];
    assign src_b = regs[issue_packet.rs2];

    ////////////////////////////////////////////////////////////
    // alu and branch compare
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_value = '0;
        taken     = 1'b0;
        // pc + 1 + offset, wraps in 8 bits
        target    = issue_packet.pc + 8'd1 + issue_packet.imm[7:0];
        case (issue_packet.opcode)
            op_add:  alu_value = src_a + src_b;
            op_sub:  alu_value = src_a - src_b;
            op_and:  alu_value = src_a & src_b;
            op_xor:  alu_value = src_a ^ src_b;
            op_addi: alu_value = src_a + issue_packet.imm;
            op_li:   alu_value = issue_packet.imm;
            op_beq:  taken     = (src_a == src_b);
            // halt and illegal only need the done flag
            default: alu_value = '0;
        endcase
    end

    // one cycle to the rob
    always_ff @(posedge clock) begin
        exec_result.tag    <= issue_tag;
        exec_result.value  <= alu_value;
        exec_result.taken  <= taken;
        exec_result.target <= target;
        if (!rst_n || squash) begin
            exec_result.valid <= 1'b0;
        end else begin
            exec_result.valid <= issue_valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic           clock,
    input  wire logic           rst_n,
    input  wire logic           alloc_valid,
    input  wire decode_packet_t alloc_packet,
    input  wire exec_result_t   exec_result,
    output rob_tag_t            alloc_tag,
    output logic                full,
    output commit_packet_t      commit_packet,
    output redirect_t           redirect,
    output logic                squash
);

    typedef struct packed {
        reg_idx_t   rd;
        logic       writes_rd;
        logic       is_branch;
        logic       done;       // result written by execute
        logic       taken;
        data_t      value;
        addr_t      target;
        addr_t      npc;        // fall-through address
        exception_e status;
    } rob_entry_t;

    rob_entry_t entries [rob_size];

    rob_tag_t                      head;
    rob_tag_t                      tail;
    logic [$clog2(rob_size+1)-1:0] count;
    logic                          stopped;    // halt or illegal retired

    rob_entry_t head_entry;
    logic       do_commit;

    ////////////////////////////////////////////////////////////
    // head and commit
    ////////////////////////////////////////////////////////////

    assign head_entry = entries[head];
    assign full       = (count == rob_size);
    assign alloc_tag  = tail;

    // retire the head in the cycle it is done
    assign do_commit = (count != '0) && head_entry.done && !stopped;

    // predicted not taken, so a taken branch squashes everything younger
    assign squash          = do_commit && head_entry.is_branch && head_entry.taken;
    assign redirect.valid  = squash;
    assign redirect.target = head_entry.target;

    assign commit_packet.valid   = do_commit;
    assign commit_packet.wr_en   = do_commit && head_entry.writes_rd;
    assign commit_packet.wr_idx  = head_entry.rd;
    assign commit_packet.wr_data = head_entry.value;
    assign commit_packet.npc     = head_entry.taken ? head_entry.target : head_entry.npc;
    assign commit_packet.status  = head_entry.status;

    ////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            count <= count + alloc_valid - do_commit;
        end
    end

    // sticky until reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stopped <= 1'b0;
        end else if (do_commit && (head_entry.status != no_error)) begin
            stopped <= 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            entries[tail].rd        <= alloc_packet.rd;
            entries[tail].writes_rd <= alloc_packet.writes_rd;
            entries[tail].is_branch <= alloc_packet.is_branch;
            entries[tail].done      <= 1'b0;
            entries[tail].npc       <= alloc_packet.pc + 1'b1;
            if (alloc_packet.illegal) begin
                entries[tail].status <= illegal_inst;
            end else if (alloc_packet.opcode == op_halt) begin
                entries[tail].status <= halted;
            end else begin
                entries[tail].status <= no_error;
            end
        end
        // tag is always an allocated slot, never the tail
        if (exec_result.valid) begin
            entries[exec_result.tag].value  <= exec_result.value;
            entries[exec_result.tag].taken  <= exec_result.taken;
            entries[exec_result.tag].target <= exec_result.target;
            entries[exec_result.tag].done   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/stage_decode.sv
`timescale 1ns/1ps
`default_nettype none

module stage_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire fetch_packet_t fetch_packet,
    output decode_packet_t     decode_packet
);

    inst_t inst;

    assign inst = fetch_packet.inst;

    always_comb begin
        // raw fields
        decode_packet.valid     = fetch_packet.valid;
        decode_packet.pc        = fetch_packet.pc;
        decode_packet.rd        = inst.rd;
        decode_packet.rs1       = inst.rs1;
        decode_packet.rs2       = inst.rs2;
        decode_packet.imm       = inst.imm;
        decode_packet.opcode    = op_halt;
        decode_packet.writes_rd = 1'b0;
        decode_packet.is_branch = 1'b0;
        decode_packet.illegal   = 1'b0;

        case (inst.opcode)
            op_add, op_sub, op_and, op_xor: begin
                decode_packet.opcode    = opcode_e'(inst.opcode);
                decode_packet.writes_rd = 1'b1;
            end
            op_addi, op_li: begin
                decode_packet.opcode    = opcode_e'(inst.opcode);
                decode_packet.writes_rd = 1'b1;
                // rs2 unused, alias rs1 so the scoreboard sees one source
                decode_packet.rs2       = inst.rs1;
            end
            op_beq: begin
                decode_packet.opcode    = op_beq;
                decode_packet.is_branch = 1'b1;
            end
            op_halt: begin
                decode_packet.opcode = op_halt;
            end
            default: begin
                // retires like halt, status marks it illegal
                decode_packet.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      rst_n,
    input  wire logic      stall,
    input  wire logic      halt,
    input  wire redirect_t redirect,
    input  wire logic      imem_req_ready,
    input  wire logic      imem_rsp_valid,
    input  wire inst_t     imem_rsp_data,
    output logic           imem_req_valid,
    output addr_t          imem_req_addr,
    output fetch_packet_t  fetch_packet
);

    addr_t         pc;          // next address to request
    logic          pending;     // accepted, response not back yet
    logic          drop;        // in-flight response is from a squashed path
    logic          halt_seen;
    fetch_packet_t held;        // response parked under stall

    logic req_fire;
    logic rsp_fire;
    logic held_next;
    logic issue_ok;

    assign req_fire = imem_req_valid && imem_req_ready;
    assign rsp_fire = pending && imem_rsp_valid;

    // parked packet first, else the live response
    always_comb begin
        if (held.valid) begin
            fetch_packet = held;
        end else begin
            fetch_packet.valid = rsp_fire && !drop;
            fetch_packet.inst  = imem_rsp_data;
            // addr register is stable while the request is outstanding
            fetch_packet.pc    = imem_req_addr;
        end
    end

    // packet still waiting after this edge
    assign held_next = fetch_packet.valid && stall;

    // one request at a time, none while a packet waits
    assign issue_ok = !halt_seen && !halt && !imem_req_valid
                   && (!pending || rsp_fire) && !held_next;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            imem_req_valid <= 1'b0;
            imem_req_addr  <= '0;
            pc             <= '0;
            pending        <= 1'b0;
            drop           <= 1'b0;
            halt_seen      <= 1'b0;
            held           <= '0;
        end else begin
            if (redirect.valid) begin
                pc      <= redirect.target;
                held    <= '0;
                // whatever is still outstanding belongs to the old path
                drop    <= imem_req_valid || (pending && !imem_rsp_valid);
                pending <= req_fire || (pending && !imem_rsp_valid);
                // an unaccepted request stays up, addr unchanged
                imem_req_valid <= imem_req_valid && !imem_req_ready;
            end else begin
                if (req_fire) begin
                    imem_req_valid <= 1'b0;
                    pending        <= 1'b1;
                end
                if (rsp_fire) begin
                    pending <= 1'b0;
                    drop    <= 1'b0;
                end
                held <= held_next ? fetch_packet : '0;
                if (issue_ok) begin
                    imem_req_valid <= 1'b1;
                    imem_req_addr  <= pc;
                    pc             <= pc + 1'b1;
                end
            end
            if (halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // reorder buffer depth
    localparam int rob_size = 8;

    typedef logic [$clog2(rob_size)-1:0] rob_tag_t;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        inst_t inst;
        addr_t pc;
    } fetch_packet_t;

    // decode to back end
    typedef struct packed {
        logic     valid;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
        logic     writes_rd;
        logic     is_branch;
        logic     illegal;
        addr_t    pc;
    } decode_packet_t;

    // fetch steering from commit
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // one retired instruction
    typedef struct packed {
        logic       valid;
        logic       wr_en;
        reg_idx_t   wr_idx;
        data_t      wr_data;
        addr_t      npc;
        exception_e status;
    } commit_packet_t;

    // execute writeback into the rob
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
        logic     taken;
        addr_t    target;
    } exec_result_t;

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // architectural register count
    localparam int arch_regs = 8;

    // word addresses, one instruction per address
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] data_t;
    typedef logic [2:0]  reg_idx_t;

    // codes 8 to 15 are unassigned and decode as illegal
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_xor  = 4'd3,
        op_addi = 4'd4,
        op_li   = 4'd5,
        op_beq  = 4'd6,
        op_halt = 4'd7
    } opcode_e;

    // instruction word layout, msb first
    typedef struct packed {
        logic [3:0] opcode;   // raw code, may fall outside opcode_e
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] spare;
        data_t      imm;
    } inst_t;

    // commit status
    typedef enum logic [1:0] {
        no_error     = 2'd0,
        halted       = 2'd1,
        illegal_inst = 2'd2
    } exception_e;

endpackage

`default_nettype wire
